// File: video_pkg.sv
// video geometry and pixel format constants
// shared by the input capture, line buffer, output timing and dimmer
`default_nettype none

package video_pkg;

	// ============================================================
	// pixel format
	// ============================================================

	// bits per colour channel coming from the shifter
	localparam int color_width = 6;

	// one buffer word holds r, g and b side by side, r on top
	localparam int pixel_width = 3 * color_width;

	// ============================================================
	// line geometry
	// ============================================================

	// horizontal position counter, up to 1024 positions per line
	localparam int hpos_width = 10;

	// picks one of the two buffered lines
	localparam int line_sel_width = 1;

	// buffer address is line select on top of the position
	localparam int buf_addr_width = line_sel_width + hpos_width;

	// divider for one input pixel every four clk_sys cycles
	localparam int ce_div_width = 2;

endpackage

`default_nettype wire

// File: scanline_pkg.sv
// scanline mode codes
// channel dimming function used on every second output line
`default_nettype none

package scanline_pkg;

	import video_pkg::*;

	// modes as seen on the scanlines input
	localparam logic [1:0] sl_none = 2'd0;
	localparam logic [1:0] sl_25   = 2'd1;
	localparam logic [1:0] sl_50   = 2'd2;
	localparam logic [1:0] sl_75   = 2'd3;

	// only the top bits of a channel survive dimming
	localparam int dim_keep_bits = 4;

	// 25% is 1/2 + 1/4, 50% is 1/2, 75% is 1/4 of the value
	function automatic logic [color_width-1:0] dim_channel(
		input logic [color_width-1:0] value,
		input logic [1:0]             mode
	);
		logic [color_width-1:0] t;
		t = {{(color_width - dim_keep_bits){1'b0}}, value[color_width-1 -: dim_keep_bits]};
		case (mode)
			sl_25:   dim_channel = (t << 1) + t;
			sl_50:   dim_channel = t << 1;
			sl_75:   dim_channel = t;
			default: dim_channel = value;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: sd_input_capture.sv
// input side of the scan doubler
// pixel enable phase lock, horizontal position counting,
// hsync timing capture and line buffer write port
`timescale 1ns/10ps
`default_nettype none

module sd_input_capture import video_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      hs_in,
	input  logic                      vs_in,
	input  logic [color_width-1:0]    r_in,
	input  logic [color_width-1:0]    g_in,
	input  logic [color_width-1:0]    b_in,
	output logic                      ce_x1,
	output logic                      ce_x2,
	output logic [hpos_width-1:0]     hs_max,
	output logic [hpos_width-1:0]     hs_rise,
	output logic [line_sel_width-1:0] line_sel,
	output logic                      wr_en,
	output logic [buf_addr_width-1:0] wr_addr,
	output logic [pixel_width-1:0]    wr_data
);

	// ============================================================
	// clock enable generation
	// ============================================================

	logic [ce_div_width-1:0] i_div;
	logic                    hs_last;

	// divider restarts right after hsync goes low
	// so the pixel phase follows the source
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_last <= 1'b0;
			i_div   <= '0;
		end else begin
			hs_last <= hs_in;
			if (hs_last && !hs_in) begin
				i_div <= '0;
			end else begin
				i_div <= i_div + ce_div_width'(1);
			end
		end
	end

	// one cycle in four for input pixels, one in two for output
	assign ce_x1 = (i_div == ce_div_width'(1));
	assign ce_x2 = i_div[0];

	// ============================================================
	// line measurement
	// ============================================================

	logic                  hs_d;
	logic                  vs_d;
	logic                  hs_falling;
	logic                  hs_rising;
	logic [hpos_width-1:0] hcnt;

	// edges seen at pixel rate
	assign hs_falling = hs_d && !hs_in;
	assign hs_rising  = !hs_d && hs_in;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			hcnt     <= '0;
			hs_max   <= '0;
			hs_rise  <= '0;
			line_sel <= '0;
		end else if (ce_x1) begin
			hs_d <= hs_in;
			vs_d <= vs_in;
			// line starts at hsync falling edge, keep the last position seen
			if (hs_falling) begin
				hs_max <= hcnt;
				hcnt   <= '0;
			end else begin
				hcnt <= hcnt + hpos_width'(1);
			end
			// where hsync ends, used to rebuild the pulse
			if (hs_rising) begin
				hs_rise <= hcnt;
			end
			// restart buffer halves at each new frame
			if (vs_d != vs_in) begin
				line_sel <= '0;
			end
			// swap halves at every line start, wins over the frame clear
			if (hs_falling) begin
				line_sel <= ~line_sel;
			end
		end
	end

	// ============================================================
	// buffer write
	// ============================================================

	assign wr_en   = ce_x1;
	assign wr_addr = {line_sel, hcnt};
	assign wr_data = {r_in, g_in, b_in};

endmodule

`default_nettype wire

// File: sd_line_buffer.sv
// two-line pixel memory
// one write port, one registered read port
`timescale 1ns/10ps
`default_nettype none

module sd_line_buffer import video_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      wr_en,
	input  logic [buf_addr_width-1:0] wr_addr,
	input  logic [pixel_width-1:0]    wr_data,
	input  logic                      rd_en,
	input  logic [buf_addr_width-1:0] rd_addr,
	output logic [pixel_width-1:0]    rd_data
);

	// two halves of 1024 words, picked by the top address bit
	logic [pixel_width-1:0] mem [0:(1 << buf_addr_width) - 1];

	// write side, plain synchronous write for block ram
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read side, data valid one clock after rd_en
	// reader and writer never touch the same half at once
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: sd_output_timing.sv
// double rate horizontal timing
// rebuilt hsync and read addressing of the finished line
`timescale 1ns/10ps
`default_nettype none

module sd_output_timing import video_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ce_x2,
	input  logic                      hs_in,
	input  logic [hpos_width-1:0]     hs_max,
	input  logic [hpos_width-1:0]     hs_rise,
	input  logic [line_sel_width-1:0] line_sel,
	output logic                      hs_sd,
	output logic                      rd_en,
	output logic [buf_addr_width-1:0] rd_addr
);

	logic                  hs_d;
	logic [hpos_width-1:0] sd_hcnt;

	// ============================================================
	// counter and sync at twice the input rate
	// ============================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_d    <= 1'b0;
			sd_hcnt <= '0;
			hs_sd   <= 1'b0;
		end else if (ce_x2) begin
			hs_d <= hs_in;
			// two passes over 0..hs_max per input line
			if (sd_hcnt == hs_max) begin
				sd_hcnt <= '0;
			end else if (hs_d && !hs_in) begin
				// input line start, jump to end so the wrap lines up
				sd_hcnt <= hs_max;
			end else begin
				sd_hcnt <= sd_hcnt + hpos_width'(1);
			end
			// pulse low from the line end up to the stored rise position
			if (sd_hcnt == hs_max) begin
				hs_sd <= 1'b0;
			end
			if (sd_hcnt == hs_rise) begin
				hs_sd <= 1'b1;
			end
		end
	end

	// ============================================================
	// buffer read
	// ============================================================

	// the half not being written holds the previous line
	assign rd_en   = ce_x2;
	assign rd_addr = {~line_sel, sd_hcnt};

endmodule

`default_nettype wire

// File: sd_scanline_dimmer.sv
// output side of the scan doubler
// scanline parity per frame, dimming and output registers
`timescale 1ns/10ps
`default_nettype none

module sd_scanline_dimmer
	import video_pkg::*;
	import scanline_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   ce_x2,
	input  logic [1:0]             scanlines,
	input  logic                   hs_sd,
	input  logic                   vs_in,
	input  logic [pixel_width-1:0] rd_data,
	output logic                   hs_out,
	output logic                   vs_out,
	output logic [color_width-1:0] r_out,
	output logic [color_width-1:0] g_out,
	output logic [color_width-1:0] b_out
);

	logic [color_width-1:0] rd_r;
	logic [color_width-1:0] rd_g;
	logic [color_width-1:0] rd_b;
	logic                   scanline;
	logic [1:0]             mode;

	// unpack buffer word, r in the top bits
	assign rd_r = rd_data[3*color_width-1 -: color_width];
	assign rd_g = rd_data[2*color_width-1 -: color_width];
	assign rd_b = rd_data[color_width-1 -: color_width];

	// flag set marks an even line of the frame, those pass straight through
	assign mode = scanline ? sl_none : scanlines;

	// ============================================================
	// output registers
	// ============================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_out   <= 1'b0;
			vs_out   <= 1'b0;
			r_out    <= '0;
			g_out    <= '0;
			b_out    <= '0;
			scanline <= 1'b0;
		end else if (ce_x2) begin
			// one more register stage keeps the outputs glitch free
			hs_out <= hs_sd;
			vs_out <= vs_in;
			// a new frame clears the flag so the next line start begins line 0
			if (vs_out != vs_in) begin
				scanline <= 1'b0;
			end
			// parity flips at each output line start
			if (hs_out && !hs_sd) begin
				scanline <= ~scanline;
			end
			r_out <= dim_channel(rd_r, mode);
			g_out <= dim_channel(rd_g, mode);
			b_out <= dim_channel(rd_b, mode);
		end
	end

endmodule

`default_nettype wire

// File: scandoubler.sv
// scan doubler top level
// input capture, line buffer, output timing and scanline dimmer
`timescale 1ns/10ps
`default_nettype none

module scandoubler import video_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	// 0 none, 1 25%, 2 50%, 3 75%
	input  logic [1:0]             scanlines,
	input  logic                   hs_in,
	input  logic                   vs_in,
	input  logic [color_width-1:0] r_in,
	input  logic [color_width-1:0] g_in,
	input  logic [color_width-1:0] b_in,
	output logic                   hs_out,
	output logic                   vs_out,
	output logic [color_width-1:0] r_out,
	output logic [color_width-1:0] g_out,
	output logic [color_width-1:0] b_out
);

	// ============================================================
	// internal nets
	// ============================================================

	logic                      ce_x1;
	logic                      ce_x2;
	logic [hpos_width-1:0]     hs_max;
	logic [hpos_width-1:0]     hs_rise;
	logic [line_sel_width-1:0] line_sel;
	logic                      wr_en;
	logic [buf_addr_width-1:0] wr_addr;
	logic [pixel_width-1:0]    wr_data;
	logic                      hs_sd;
	logic                      rd_en;
	logic [buf_addr_width-1:0] rd_addr;
	logic [pixel_width-1:0]    rd_data;

	// source side, pixel rate
	sd_input_capture u_input_capture (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.hs_in    (hs_in),
		.vs_in    (vs_in),
		.r_in     (r_in),
		.g_in     (g_in),
		.b_in     (b_in),
		.ce_x1    (ce_x1),
		.ce_x2    (ce_x2),
		.hs_max   (hs_max),
		.hs_rise  (hs_rise),
		.line_sel (line_sel),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	sd_line_buffer u_line_buffer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// display side, twice the pixel rate
	sd_output_timing u_output_timing (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ce_x2    (ce_x2),
		.hs_in    (hs_in),
		.hs_max   (hs_max),
		.hs_rise  (hs_rise),
		.line_sel (line_sel),
		.hs_sd    (hs_sd),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr)
	);

	sd_scanline_dimmer u_scanline_dimmer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.ce_x2     (ce_x2),
		.scanlines (scanlines),
		.hs_sd     (hs_sd),
		.vs_in     (vs_in),
		.rd_data   (rd_data),
		.hs_out    (hs_out),
		.vs_out    (vs_out),
		.r_out     (r_out),
		.g_out     (g_out),
		.b_out     (b_out)
	);

endmodule

`default_nettype wire

// File: tb_checker.sv
// checker for the scan doubler testbench
// watches the DUT ports, models scanline parity and compares outputs
`timescale 1ns/10ps
`default_nettype none

module tb_checker import video_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   check_en,
	input  logic [1:0]             exp_mode,
	input  logic [color_width-1:0] exp_r,
	input  logic [color_width-1:0] exp_g,
	input  logic [color_width-1:0] exp_b,
	input  logic                   vs_in,
	input  logic                   hs_out,
	input  logic                   vs_out,
	input  logic [color_width-1:0] r_out,
	input  logic [color_width-1:0] g_out,
	input  logic [color_width-1:0] b_out,
	output int                     error_count,
	output int                     sample_count
);

	// output line is half of the 256 cycle input line
	localparam int out_line_clks = 128;
	localparam int hs_high_clks  = 16;
	localparam int mid_line_clks = 64;

	int   cycle     = 0;
	int   rel_cnt   = 0;
	int   vs_stable = 0;
	int   last_fall = 0;
	int   last_rise = 0;
	int   sample_at = -1;
	logic hs_q      = 1'b0;
	logic vs_in_q   = 1'b0;
	logic vs_out_q  = 1'b0;
	logic parity    = 1'b1;

	initial begin
		error_count  = 0;
		sample_count = 0;
	end

	// top four bits kept, 25% leaves three quarters of them
	function automatic logic [color_width-1:0] dimmed(
		input logic [color_width-1:0] v,
		input logic [1:0]             mode
	);
		logic [color_width-1:0] t;
		t = {2'b00, v[color_width-1:2]};
		case (mode)
			2'd1:    return t + t + t;
			2'd2:    return t + t;
			2'd3:    return t;
			default: return v;
		endcase
	endfunction

	task automatic compare_color(input string name, input logic [color_width-1:0] expected,
			input logic [color_width-1:0] actual);
		if (expected !== actual) begin
			error_count = error_count + 1;
			$display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic compare_level(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			error_count = error_count + 1;
			$display("[FAIL] time %0t %s expected %0b actual %0b", $time, name, expected, actual);
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			error_count = error_count + 1;
			$display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	// ============================================================
	// sampling on the falling clock edge, away from DUT updates
	// ============================================================

	always @(negedge clk_sys) begin
		logic [color_width-1:0] er;
		logic [color_width-1:0] eg;
		logic [color_width-1:0] eb;
		cycle = cycle + 1;
		// outputs stay cleared in reset and through the first ce tick
		if (!arst_n || rel_cnt < 3) begin
			if (arst_n) begin
				rel_cnt = rel_cnt + 1;
			end else begin
				rel_cnt = 0;
			end
			compare_level("hs_out", 1'b0, hs_out);
			compare_level("vs_out", 1'b0, vs_out);
			compare_color("r_out", '0, r_out);
			compare_color("g_out", '0, g_out);
			compare_color("b_out", '0, b_out);
		end
		// vs_out has at most two cycles to catch up
		if (vs_in != vs_in_q) begin
			vs_stable = 0;
		end else begin
			vs_stable = vs_stable + 1;
		end
		if (vs_stable >= 2 && arst_n) begin
			compare_level("vs_out", vs_in, vs_out);
		end
		// the first line start after vs_out moves is line 0 of the frame
		// so parity rests on odd until then
		if (vs_out != vs_out_q) begin
			parity = 1'b1;
		end
		if (hs_q && !hs_out) begin
			parity = ~parity;
			if (check_en && last_fall > 0) begin
				compare_count("hs_out period", out_line_clks, cycle - last_fall);
				if (last_rise > last_fall) begin
					compare_count("hs_out high width", hs_high_clks, cycle - last_rise);
				end
			end
			last_fall = check_en ? cycle : 0;
			sample_at = cycle + mid_line_clks;
		end
		if (!hs_q && hs_out) begin
			last_rise = cycle;
		end
		// mid line colour, dimmed only on odd lines of the frame
		if (check_en && cycle == sample_at) begin
			sample_count = sample_count + 1;
			er = parity ? dimmed(exp_r, exp_mode) : exp_r;
			eg = parity ? dimmed(exp_g, exp_mode) : exp_g;
			eb = parity ? dimmed(exp_b, exp_mode) : exp_b;
			compare_color("r_out", er, r_out);
			compare_color("g_out", eg, g_out);
			compare_color("b_out", eb, b_out);
		end
		hs_q     = hs_out;
		vs_in_q  = vs_in;
		vs_out_q = vs_out;
	end

endmodule

`default_nettype wire

// File: tb_scandoubler.sv
// testbench top for the scan doubler
// clock, reset, stimulus table, line generator, watchdog and report
`timescale 1ns/10ps
`default_nettype none

module tb_scandoubler import video_pkg::*; import scanline_pkg::*; ();

	// input line geometry
	localparam int line_pixels    = 64;
	localparam int pixel_clks     = 4;
	localparam int hs_high_pixels = 8;
	localparam int clk_period     = 10;
	localparam int row_count      = 8;
	localparam int tail_lines     = 2;

	logic                   clk_sys = 1'b0;
	logic                   arst_n;
	logic [1:0]             scanlines;
	logic                   hs_in;
	logic                   vs_in;
	logic [color_width-1:0] r_in;
	logic [color_width-1:0] g_in;
	logic [color_width-1:0] b_in;
	logic                   hs_out;
	logic                   vs_out;
	logic [color_width-1:0] r_out;
	logic [color_width-1:0] g_out;
	logic [color_width-1:0] b_out;

	// expected values handed to the checker
	logic                   check_en;
	logic [1:0]             exp_mode;
	logic [color_width-1:0] exp_r;
	logic [color_width-1:0] exp_g;
	logic [color_width-1:0] exp_b;
	int                     error_count;
	int                     sample_count;

	// stimulus table, one row per run of lines
	logic [1:0]             tbl_mode   [row_count];
	logic                   tbl_frame  [row_count];
	logic                   tbl_random [row_count];
	logic [color_width-1:0] tbl_r      [row_count];
	logic [color_width-1:0] tbl_g      [row_count];
	logic [color_width-1:0] tbl_b      [row_count];
	int                     tbl_lines  [row_count];

	logic [color_width-1:0] last_r = '0;
	logic [color_width-1:0] last_g = '0;
	logic [color_width-1:0] last_b = '0;
	int                     lines_done = 0;

	always #(clk_period / 2) clk_sys = ~clk_sys;

	scandoubler dut (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.scanlines (scanlines),
		.hs_in     (hs_in),
		.vs_in     (vs_in),
		.r_in      (r_in),
		.g_in      (g_in),
		.b_in      (b_in),
		.hs_out    (hs_out),
		.vs_out    (vs_out),
		.r_out     (r_out),
		.g_out     (g_out),
		.b_out     (b_out)
	);

	tb_checker u_checker (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.check_en     (check_en),
		.exp_mode     (exp_mode),
		.exp_r        (exp_r),
		.exp_g        (exp_g),
		.exp_b        (exp_b),
		.vs_in        (vs_in),
		.hs_out       (hs_out),
		.vs_out       (vs_out),
		.r_out        (r_out),
		.g_out        (g_out),
		.b_out        (b_out),
		.error_count  (error_count),
		.sample_count (sample_count)
	);

	task automatic set_row(input int i, input logic [1:0] mode, input logic frame,
			input logic rnd, input logic [17:0] rgb, input int lines);
		tbl_mode[i]   = mode;
		tbl_frame[i]  = frame;
		tbl_random[i] = rnd;
		tbl_r[i]      = rgb[17:12];
		tbl_g[i]      = rgb[11:6];
		tbl_b[i]      = rgb[5:0];
		tbl_lines[i]  = lines;
	endtask

	// ============================================================
	// one input line, hsync falls at pixel 0, high for the last 8
	// ============================================================

	task automatic drive_line(input logic [color_width-1:0] r, input logic [color_width-1:0] g,
			input logic [color_width-1:0] b, input logic [1:0] mode, input logic toggle_vs);
		for (int p = 0; p < line_pixels; p++) begin
			for (int c = 0; c < pixel_clks; c++) begin
				@(posedge clk_sys);
				if (p == 0 && c == 0) begin
					hs_in     <= 1'b0;
					vs_in     <= toggle_vs ? ~vs_in : vs_in;
					scanlines <= mode;
					exp_mode  <= mode;
					r_in      <= r;
					g_in      <= g;
					b_in      <= b;
					// output now replays the line that just ended
					exp_r     <= last_r;
					exp_g     <= last_g;
					exp_b     <= last_b;
					check_en  <= (lines_done >= 3);
				end else if (p == line_pixels - hs_high_pixels && c == 0) begin
					hs_in <= 1'b1;
				end
			end
		end
		last_r     = r;
		last_g     = g;
		last_b     = b;
		lines_done = lines_done + 1;
	endtask

	function automatic int total_lines();
		int n;
		n = tail_lines;
		for (int i = 0; i < row_count; i++) begin
			n = n + tbl_lines[i];
		end
		return n;
	endfunction

	// watchdog, every line plus 50 lines of slack
	initial begin
		#1;
		#((total_lines() + 50) * line_pixels * pixel_clks * clk_period);
		$display("timeout: the stimulus did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [color_width-1:0] r;
		logic [color_width-1:0] g;
		logic [color_width-1:0] b;
		void'($urandom(32'h124d_a806));
		arst_n    <= 1'b0;
		scanlines <= sl_none;
		hs_in     <= 1'b1;
		vs_in     <= 1'b0;
		r_in      <= '0;
		g_in      <= '0;
		b_in      <= '0;
		check_en  <= 1'b0;
		exp_mode  <= sl_none;
		exp_r     <= '0;
		exp_g     <= '0;
		exp_b     <= '0;
		set_row(0, sl_none, 1'b0, 1'b0, 18'h3f015, 6);
		set_row(1, sl_none, 1'b0, 1'b1, 18'h0, 4);
		set_row(2, sl_25, 1'b1, 1'b0, 18'h2a57f, 4);
		set_row(3, sl_50, 1'b0, 1'b1, 18'h0, 4);
		set_row(4, sl_75, 1'b1, 1'b0, 18'h3c3f3, 4);
		set_row(5, sl_25, 1'b1, 1'b1, 18'h0, 5);
		set_row(6, sl_none, 1'b1, 1'b0, 18'h01083, 3);
		set_row(7, sl_50, 1'b1, 1'b0, 18'h3ffff, 3);
		repeat (5) @(posedge clk_sys);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < row_count; i++) begin
			for (int n = 0; n < tbl_lines[i]; n++) begin
				r = tbl_random[i] ? 6'($urandom) : tbl_r[i];
				g = tbl_random[i] ? 6'($urandom) : tbl_g[i];
				b = tbl_random[i] ? 6'($urandom) : tbl_b[i];
				drive_line(r, g, b, tbl_mode[i], tbl_frame[i] && n == 0);
			end
		end
		// black tail lines so the last row gets replayed
		for (int n = 0; n < tail_lines; n++) begin
			drive_line('0, '0, '0, tbl_mode[row_count-1], 1'b0);
		end
		repeat (20) @(posedge clk_sys);
		if (sample_count == 0) begin
			$display("no colour samples were compared");
		end
		$display("errors: %0d, colour samples: %0d", error_count, sample_count);
		if (error_count == 0 && sample_count > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
video_pkg.sv
scanline_pkg.sv
sd_input_capture.sv
sd_line_buffer.sv
sd_output_timing.sv
sd_scanline_dimmer.sv
scandoubler.sv
tb_checker.sv
tb_scandoubler.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the scan doubler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_scandoubler \
	-o sim_scandoubler > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_scandoubler > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation log has no result line"
	exit 1
fi
exit 0
